//--- src/fftAxilSlave.sv
`timescale 1ns/1ns
`default_nettype none

module fftAxilSlave import fftPkg::*; (
    input  logic                  clock_i,
    input  logic                  arstN_i,
    input  logic [AXI_ADDR_W-1:0] awaddr_i,
    input  logic                  awvalid_i,
    output logic                  awready_o,
    input  logic [AXI_DATA_W-1:0] wdata_i,
    input  logic                  wvalid_i,
    output logic                  wready_o,
    output logic                  bvalid_o,
    input  logic                  bready_i,
    output logic [1:0]            bresp_o,
    input  logic [AXI_ADDR_W-1:0] araddr_i,
    input  logic                  arvalid_i,
    output logic                  arready_o,
    output logic                  rvalid_o,
    input  logic                  rready_i,
    output logic [AXI_DATA_W-1:0] rdata_o,
    output logic [1:0]            rresp_o,
    output logic                  start_o,
    input  logic                  busy_i,
    input  logic                  done_i,
    output logic                  loadWe_o,
    output logic [ADDR_W-1:0]     loadAddr_o,
    output cplx_t                 loadData_o,
    output logic [ADDR_W-1:0]     rdAddr_o,
    input  cplx_t                 rdData_i
);

    cplxWord_t wrWord;
    cplxWord_t rdWord;
    logic wrAccept;
    logic wrSample;
    logic [1:0] wrResp;
    logic rdAccept;
    logic rdSample;
    logic [1:0] rdResp;
    logic [AXI_DATA_W-1:0] rdDirect;
    logic rdPend;
    logic rdFromMem;
    logic rdFresh;
    logic [AXI_DATA_W-1:0] rdataQ;

    // Address and data are taken in the same cycle once no response is pending.
    assign awready_o = awvalid_i & wvalid_i & ~bvalid_o;
    assign wready_o = awready_o;
    assign wrAccept = awready_o;
    assign wrSample = (awaddr_i < CTRL_ADDR);

    assign wrWord.raw = wdata_i;
    assign loadWe_o = wrAccept & wrSample & ~busy_i;
    assign loadAddr_o = awaddr_i[ADDR_W+1:2];
    assign loadData_o = wrWord.c;
    assign start_o = wrAccept & (awaddr_i == CTRL_ADDR) & wdata_i[0] & ~busy_i;

    always_comb begin
        if (wrSample) begin
            wrResp = busy_i ? RESP_SLVERR : RESP_OKAY;
        end else if (awaddr_i == CTRL_ADDR) begin
            wrResp = RESP_OKAY;
        end else begin
            wrResp = RESP_SLVERR;
        end
    end

    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            bvalid_o <= 1'b0;
        end else if (wrAccept) begin
            bvalid_o <= 1'b1;
        end else if (bready_i) begin
            bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clock_i) begin
        if (wrAccept) begin
            bresp_o <= wrResp;
        end
    end

    // A read occupies the channel from acceptance until rready, two cycles
    // of which pass before rvalid.
    assign arready_o = arvalid_i & ~rdPend & ~rvalid_o;
    assign rdAccept = arready_o;
    assign rdSample = (araddr_i < CTRL_ADDR);

    always_comb begin
        rdDirect = '0;
        if (araddr_i == STATUS_ADDR) begin
            rdDirect = {{(AXI_DATA_W-2){1'b0}}, done_i, busy_i};
        end
        if (rdSample) begin
            rdResp = busy_i ? RESP_SLVERR : RESP_OKAY;
        end else if (araddr_i == STATUS_ADDR || araddr_i == CTRL_ADDR) begin
            rdResp = RESP_OKAY;
        end else begin
            rdResp = RESP_SLVERR;
        end
    end

    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            rdPend <= 1'b0;
            rdFromMem <= 1'b0;
            rdFresh <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            rdPend <= rdAccept;
            rdFresh <= rdPend & rdFromMem;
            if (rdAccept) begin
                rdFromMem <= rdSample & ~busy_i;
            end
            if (rdPend) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (rdAccept) begin
            rdAddr_o <= araddr_i[ADDR_W+1:2];
            rdataQ <= rdDirect;
            rresp_o <= rdResp;
        end else if (rdFresh) begin
            rdataQ <= rdWord.raw;
        end
    end

    // Memory data is passed straight through for its first cycle and held
    // afterwards, since the bank may be rewritten while rvalid waits.
    assign rdWord.c = rdData_i;
    assign rdata_o = rdFresh ? rdWord.raw : rdataQ;

endmodule

`default_nettype wire

//--- src/fftButterfly.sv
`timescale 1ns/1ns
`default_nettype none

module fftButterfly import fftPkg::*; (
    input  logic              clock_i,
    input  logic              arstN_i,
    input  logic [ADDR_W-2:0] twIdx_i,
    fftMemIf.bfly             portG,
    fftMemIf.bfly             portH
);

    localparam int TW_FRAC = 14;

    cplx_t twQ;
    cplx_t aQ;
    cplx_t mulQ;
    logic signed [2*DATA_W:0] prodRe;
    logic signed [2*DATA_W:0] prodIm;
    logic signed [DATA_W:0] sumRe;
    logic signed [DATA_W:0] sumIm;
    logic signed [DATA_W:0] difRe;
    logic signed [DATA_W:0] difIm;

    // Cosine and negative sine of 2*pi*k/32 in Q1.14.
    function automatic cplx_t twiddle(input logic [ADDR_W-2:0] k);
        cplx_t w;
        case (k)
            4'd0:  w = '{re:  16'sd16384, im:  16'sd0};
            4'd1:  w = '{re:  16'sd16069, im: -16'sd3196};
            4'd2:  w = '{re:  16'sd15137, im: -16'sd6270};
            4'd3:  w = '{re:  16'sd13623, im: -16'sd9102};
            4'd4:  w = '{re:  16'sd11585, im: -16'sd11585};
            4'd5:  w = '{re:  16'sd9102,  im: -16'sd13623};
            4'd6:  w = '{re:  16'sd6270,  im: -16'sd15137};
            4'd7:  w = '{re:  16'sd3196,  im: -16'sd16069};
            4'd8:  w = '{re:  16'sd0,     im: -16'sd16384};
            4'd9:  w = '{re: -16'sd3196,  im: -16'sd16069};
            4'd10: w = '{re: -16'sd6270,  im: -16'sd15137};
            4'd11: w = '{re: -16'sd9102,  im: -16'sd13623};
            4'd12: w = '{re: -16'sd11585, im: -16'sd11585};
            4'd13: w = '{re: -16'sd13623, im: -16'sd9102};
            4'd14: w = '{re: -16'sd15137, im: -16'sd6270};
            default: w = '{re: -16'sd16069, im: -16'sd3196};
        endcase
        return w;
    endfunction

    always_comb begin
        prodRe = portH.rdata.re * twQ.re - portH.rdata.im * twQ.im;
        prodIm = portH.rdata.re * twQ.im + portH.rdata.im * twQ.re;
        sumRe = aQ.re + mulQ.re;
        sumIm = aQ.im + mulQ.im;
        difRe = aQ.re - mulQ.re;
        difIm = aQ.im - mulQ.im;
    end

    // The twiddle is fetched alongside the operand read, so both arrive in
    // the multiply cycle. Each stage halves its outputs.
    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            twQ <= '0;
            aQ <= '0;
            mulQ <= '0;
            portG.wdata <= '0;
            portH.wdata <= '0;
        end else begin
            twQ <= twiddle(twIdx_i);
            aQ <= portG.rdata;
            mulQ.re <= prodRe[TW_FRAC +: DATA_W];
            mulQ.im <= prodIm[TW_FRAC +: DATA_W];
            portG.wdata.re <= sumRe[DATA_W:1];
            portG.wdata.im <= sumIm[DATA_W:1];
            portH.wdata.re <= difRe[DATA_W:1];
            portH.wdata.im <= difIm[DATA_W:1];
        end
    end

endmodule

`default_nettype wire

//--- src/fftDataMem.sv
`timescale 1ns/1ns
`default_nettype none

module fftDataMem import fftPkg::*; (
    input  logic              clock_i,
    input  logic              stageOdd_i,
    input  logic              loadWe_i,
    input  logic [ADDR_W-1:0] loadAddr_i,
    input  cplx_t             loadData_i,
    input  logic [ADDR_W-1:0] rdAddr_i,
    output cplx_t             rdData_o,
    fftMemIf.mem              portG,
    fftMemIf.mem              portH
);

    logic [ADDR_W-1:0] loadRev;

    // Samples are stored in bit-reversed order so that results come out natural.
    assign loadRev = {<<{loadAddr_i}};

    for (genvar b = 0; b < 2; b++) begin : gBank
        cplx_t ram [FFT_POINTS];
        logic isWr;
        logic [ADDR_W-1:0] addrG;
        logic [ADDR_W-1:0] addrH;
        logic weG;
        logic weH;
        cplx_t dinG;
        cplx_t dinH;
        cplx_t rdG;
        cplx_t rdH;

        // An odd stage reads bank 1 and writes bank 0.
        assign isWr = (b == 0) ? stageOdd_i : ~stageOdd_i;

        always_comb begin
            addrG = isWr ? portG.wrAddr : portG.rdAddr;
            addrH = isWr ? portH.wrAddr : portH.rdAddr;
            weG = isWr & portG.we;
            weH = isWr & portH.we;
            dinG = portG.wdata;
            dinH = portH.wdata;
            if (b == 0 && loadWe_i) begin
                addrG = loadRev;
                weG = 1'b1;
                dinG = loadData_i;
            end
            // Port G of bank 1 serves readback whenever it is not being written.
            if (b == 1 && isWr && !portG.we) begin
                addrG = rdAddr_i;
            end
        end

        always_ff @(posedge clock_i) begin
            if (weG) begin
                ram[addrG] <= dinG;
            end
            if (weH) begin
                ram[addrH] <= dinH;
            end
            rdG <= ram[addrG];
            rdH <= ram[addrH];
        end
    end

    assign portG.rdata = stageOdd_i ? gBank[1].rdG : gBank[0].rdG;
    assign portH.rdata = stageOdd_i ? gBank[1].rdH : gBank[0].rdH;
    assign rdData_o = gBank[1].rdG;

endmodule

`default_nettype wire

//--- src/fftMemIf.sv
`timescale 1ns/1ns
`default_nettype none

interface fftMemIf import fftPkg::*; ();

    // Read and write addresses are separate because reads of one stage overlap
    // with delayed writes to the opposite bank.
    logic [ADDR_W-1:0] rdAddr;
    logic [ADDR_W-1:0] wrAddr;
    logic we;
    cplx_t wdata;
    cplx_t rdata;

    modport seq (
        output rdAddr,
        output wrAddr,
        output we
    );

    modport bfly (
        output wdata,
        input  rdata
    );

    modport mem (
        input  rdAddr,
        input  wrAddr,
        input  we,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- src/fftPkg.sv
`default_nettype none

package fftPkg;

    localparam int FFT_POINTS = 32;
    localparam int ADDR_W = 5;
    localparam int STAGES = 5;
    localparam int DATA_W = 16;

    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 2 * DATA_W;

    // Real part sits in the upper half of the word.
    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } cplx_t;

    typedef union packed {
        logic [AXI_DATA_W-1:0] raw;
        cplx_t c;
    } cplxWord_t;

    // Sample words occupy 0x00 to 0x7C, one per index.
    localparam logic [AXI_ADDR_W-1:0] CTRL_ADDR = 8'h80;
    localparam logic [AXI_ADDR_W-1:0] STATUS_ADDR = 8'h84;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- src/fftSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module fftSequencer import fftPkg::*; (
    input  logic              clock_i,
    input  logic              arstN_i,
    input  logic              start_i,
    output logic              busy_o,
    output logic              done_o,
    fftMemIf.seq              portG,
    fftMemIf.seq              portH,
    output logic [ADDR_W-2:0] twIdx_o,
    output logic              stageOdd_o
);

    localparam int LAT = 3;
    localparam int STAGE_W = $clog2(STAGES);

    logic [STAGE_W-1:0] stage;
    logic [ADDR_W-2:0] bflyCnt;
    logic draining;
    logic [1:0] drainCnt;
    logic issue;
    logic [ADDR_W-1:0] jx;
    logic [ADDR_W-1:0] spanMask;
    logic [ADDR_W-1:0] idxG;
    logic [ADDR_W-1:0] idxH;
    logic [LAT-1:0] weDly;
    logic [ADDR_W-1:0] gDly [LAT];
    logic [ADDR_W-1:0] hDly [LAT];

    assign issue = busy_o & ~draining;
    assign stageOdd_o = stage[0];

    // The upper index is the butterfly count with a zero inserted at bit
    // position stage, and the lower index sets that bit.
    always_comb begin
        jx = {1'b0, bflyCnt};
        spanMask = (ADDR_W'(1) << stage) - 1'b1;
        idxG = ((jx & ~spanMask) << 1) | (jx & spanMask);
        idxH = idxG | (ADDR_W'(1) << stage);
        twIdx_o = (bflyCnt & spanMask[ADDR_W-2:0]) << (STAGES - 1 - stage);
    end

    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            stage <= '0;
            bflyCnt <= '0;
            draining <= 1'b0;
            drainCnt <= '0;
        end else if (start_i && !busy_o) begin
            busy_o <= 1'b1;
            done_o <= 1'b0;
            stage <= '0;
            bflyCnt <= '0;
            draining <= 1'b0;
        end else if (busy_o) begin
            if (!draining) begin
                bflyCnt <= bflyCnt + 1'b1;
                if (&bflyCnt) begin
                    draining <= 1'b1;
                    drainCnt <= '0;
                end
            end else begin
                drainCnt <= drainCnt + 1'b1;
                if (drainCnt == 2'(LAT - 1)) begin
                    draining <= 1'b0;
                    if (stage == STAGE_W'(STAGES - 1)) begin
                        busy_o <= 1'b0;
                        done_o <= 1'b1;
                        stage <= '0;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
            end
        end
    end

    // Write addresses follow the reads through the butterfly pipeline.
    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            weDly <= '0;
        end else begin
            weDly <= {weDly[LAT-2:0], issue};
        end
    end

    always_ff @(posedge clock_i) begin
        gDly[0] <= idxG;
        hDly[0] <= idxH;
        for (int i = 1; i < LAT; i++) begin
            gDly[i] <= gDly[i-1];
            hDly[i] <= hDly[i-1];
        end
    end

    assign portG.rdAddr = idxG;
    assign portH.rdAddr = idxH;
    assign portG.wrAddr = gDly[LAT-1];
    assign portH.wrAddr = hDly[LAT-1];
    assign portG.we = weDly[LAT-1];
    assign portH.we = weDly[LAT-1];

endmodule

`default_nettype wire

//--- src/fftTop.sv
`timescale 1ns/1ns
`default_nettype none

module fftTop import fftPkg::*; (
    input  logic                  clock_i,
    input  logic                  arstN_i,
    input  logic [AXI_ADDR_W-1:0] awaddr_i,
    input  logic                  awvalid_i,
    output logic                  awready_o,
    input  logic [AXI_DATA_W-1:0] wdata_i,
    input  logic                  wvalid_i,
    output logic                  wready_o,
    output logic                  bvalid_o,
    input  logic                  bready_i,
    output logic [1:0]            bresp_o,
    input  logic [AXI_ADDR_W-1:0] araddr_i,
    input  logic                  arvalid_i,
    output logic                  arready_o,
    output logic                  rvalid_o,
    input  logic                  rready_i,
    output logic [AXI_DATA_W-1:0] rdata_o,
    output logic [1:0]            rresp_o
);

    logic start;
    logic busy;
    logic done;
    logic loadWe;
    logic [ADDR_W-1:0] loadAddr;
    cplx_t loadData;
    logic [ADDR_W-1:0] rdAddr;
    cplx_t rdData;
    logic [ADDR_W-2:0] twIdx;
    logic stageOdd;

    fftMemIf portG ();
    fftMemIf portH ();

    fftAxilSlave uSlave (
        .clock_i    (clock_i),
        .arstN_i    (arstN_i),
        .awaddr_i   (awaddr_i),
        .awvalid_i  (awvalid_i),
        .awready_o  (awready_o),
        .wdata_i    (wdata_i),
        .wvalid_i   (wvalid_i),
        .wready_o   (wready_o),
        .bvalid_o   (bvalid_o),
        .bready_i   (bready_i),
        .bresp_o    (bresp_o),
        .araddr_i   (araddr_i),
        .arvalid_i  (arvalid_i),
        .arready_o  (arready_o),
        .rvalid_o   (rvalid_o),
        .rready_i   (rready_i),
        .rdata_o    (rdata_o),
        .rresp_o    (rresp_o),
        .start_o    (start),
        .busy_i     (busy),
        .done_i     (done),
        .loadWe_o   (loadWe),
        .loadAddr_o (loadAddr),
        .loadData_o (loadData),
        .rdAddr_o   (rdAddr),
        .rdData_i   (rdData)
    );

    fftSequencer uSeq (
        .clock_i    (clock_i),
        .arstN_i    (arstN_i),
        .start_i    (start),
        .busy_o     (busy),
        .done_o     (done),
        .portG      (portG.seq),
        .portH      (portH.seq),
        .twIdx_o    (twIdx),
        .stageOdd_o (stageOdd)
    );

    fftButterfly uBfly (
        .clock_i (clock_i),
        .arstN_i (arstN_i),
        .twIdx_i (twIdx),
        .portG   (portG.bfly),
        .portH   (portH.bfly)
    );

    fftDataMem uMem (
        .clock_i    (clock_i),
        .stageOdd_i (stageOdd),
        .loadWe_i   (loadWe),
        .loadAddr_i (loadAddr),
        .loadData_i (loadData),
        .rdAddr_i   (rdAddr),
        .rdData_o   (rdData),
        .portG      (portG.mem),
        .portH      (portH.mem)
    );

endmodule

`default_nettype wire

//--- tb.f
src/fftPkg.sv
src/fftMemIf.sv
src/fftAxilSlave.sv
src/fftSequencer.sv
src/fftButterfly.sv
src/fftDataMem.sv
src/fftTop.sv
test/fftTop_sva.sv
test/fftTb.sv

//--- test/fftTb.sv
`timescale 1ns/1ns
`default_nettype none

module fftTb import fftPkg::*; ();

    localparam int HANDSHAKE_LIMIT = 64;
    localparam int POLL_LIMIT = 200;
    localparam logic signed [DATA_W-1:0] DC_LEVEL = 16'sh0400;
    localparam logic signed [DATA_W-1:0] IMPULSE = 16'sh2000;
    // Every stage halves, so each bin of an impulse is the impulse over 32.
    localparam logic signed [DATA_W-1:0] IMPULSE_BIN = IMPULSE / FFT_POINTS;

    logic clock;
    logic arstN;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic [1:0] bresp;
    logic [AXI_ADDR_W-1:0] araddr;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0] rresp;
    logic stallEn;

    fftTop dut (
        .clock_i   (clock),
        .arstN_i   (arstN),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .bresp_o   (bresp),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .rdata_o   (rdata),
        .rresp_o   (rresp)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    function automatic logic [AXI_DATA_W-1:0] packCplx(input logic signed [DATA_W-1:0] re,
                                                       input logic signed [DATA_W-1:0] im);
        return {re, im};
    endfunction

    task automatic timedOut(input string what);
        $display("Timeout while waiting for %s.", what);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped after a timeout.");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expVal, actVal);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first mismatch.");
    endtask

    task automatic expectEq(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        assert (actVal === expVal) else reportMismatch(name, expVal, actVal);
    endtask

    // Valid is held until the response shows up. The slave accepts nothing
    // new while that response is pending, so no second transfer can start.
    task automatic axiWrite(input logic [AXI_ADDR_W-1:0] addr,
                            input logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        int waitCnt;
        logic ack;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        waitCnt = 0;
        do begin
            @(negedge clock);
            waitCnt++;
            if (waitCnt > HANDSHAKE_LIMIT) begin
                timedOut("the write response");
            end
        end while (!bvalid);
        expectEq("awready", 1'b0, awready);
        expectEq("wready", 1'b0, wready);
        awvalid = 1'b0;
        wvalid = 1'b0;
        ack = 1'b0;
        waitCnt = 0;
        while (!ack) begin
            if (waitCnt > HANDSHAKE_LIMIT) begin
                timedOut("the write response handshake");
            end
            ack = !stallEn || (waitCnt > 0 && $urandom_range(1) == 1);
            bready = ack;
            resp = bresp;
            @(negedge clock);
            waitCnt++;
        end
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [AXI_ADDR_W-1:0] addr,
                           output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        int waitCnt;
        logic ack;
        araddr = addr;
        arvalid = 1'b1;
        waitCnt = 0;
        do begin
            @(negedge clock);
            waitCnt++;
            if (waitCnt > HANDSHAKE_LIMIT) begin
                timedOut("the read response");
            end
        end while (!rvalid);
        expectEq("arready", 1'b0, arready);
        arvalid = 1'b0;
        ack = 1'b0;
        waitCnt = 0;
        while (!ack) begin
            if (waitCnt > HANDSHAKE_LIMIT) begin
                timedOut("the read response handshake");
            end
            ack = !stallEn || (waitCnt > 0 && $urandom_range(1) == 1);
            rready = ack;
            data = rdata;
            resp = rresp;
            @(negedge clock);
            waitCnt++;
        end
        rready = 1'b0;
    endtask

    task automatic loadSamples(input logic [AXI_DATA_W-1:0] first,
                               input logic [AXI_DATA_W-1:0] rest);
        logic [1:0] resp;
        for (int k = 0; k < FFT_POINTS; k++) begin
            axiWrite(AXI_ADDR_W'(k * 4), (k == 0) ? first : rest, resp);
            expectEq("bresp", RESP_OKAY, resp);
        end
    endtask

    task automatic startTransform();
        logic [1:0] resp;
        axiWrite(CTRL_ADDR, 32'h1, resp);
        expectEq("bresp", RESP_OKAY, resp);
    endtask

    task automatic waitDone();
        logic [AXI_DATA_W-1:0] status;
        logic [1:0] resp;
        int polls;
        polls = 0;
        do begin
            if (polls == POLL_LIMIT) begin
                timedOut("the transform to finish");
            end
            axiRead(STATUS_ADDR, status, resp);
            expectEq("rresp", RESP_OKAY, resp);
            polls++;
        end while (!status[1]);
        expectEq("status", 32'h2, status);
    endtask

    task automatic checkBins(input logic [AXI_DATA_W-1:0] bin0,
                             input logic [AXI_DATA_W-1:0] others);
        logic [AXI_DATA_W-1:0] data;
        logic [1:0] resp;
        for (int k = 0; k < FFT_POINTS; k++) begin
            axiRead(AXI_ADDR_W'(k * 4), data, resp);
            expectEq($sformatf("rresp bin %0d", k), RESP_OKAY, resp);
            expectEq($sformatf("rdata bin %0d", k), (k == 0) ? bin0 : others, data);
        end
    endtask

    initial begin
        logic [AXI_DATA_W-1:0] data;
        logic [1:0] resp;
        void'($urandom(32'h62b7_a1a2));
        arstN = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        stallEn = 1'b0;
        repeat (8) @(negedge clock);
        arstN = 1'b1;
        @(negedge clock);

        axiRead(STATUS_ADDR, data, resp);
        expectEq("status", 32'h0, data);
        expectEq("rresp", RESP_OKAY, resp);

        // A constant input leaves only bin 0, at the input level.
        loadSamples(packCplx(DC_LEVEL, 0), packCplx(DC_LEVEL, 0));
        startTransform();
        waitDone();
        checkBins(packCplx(DC_LEVEL, 0), 32'h0);

        // Impulse run, with rejected accesses and a second start while busy.
        loadSamples(packCplx(IMPULSE, 0), 32'h0);
        startTransform();
        axiRead(STATUS_ADDR, data, resp);
        expectEq("status", 32'h1, data);
        expectEq("rresp", RESP_OKAY, resp);
        axiWrite(AXI_ADDR_W'(5 * 4), 32'h7fff_7fff, resp);
        expectEq("bresp", RESP_SLVERR, resp);
        axiRead(AXI_ADDR_W'(0), data, resp);
        expectEq("rresp", RESP_SLVERR, resp);
        expectEq("rdata", 32'h0, data);
        axiWrite(CTRL_ADDR, 32'h1, resp);
        expectEq("bresp", RESP_OKAY, resp);
        waitDone();
        checkBins(packCplx(IMPULSE_BIN, 0), packCplx(IMPULSE_BIN, 0));

        // Same results again with random ready stalls on both responses.
        stallEn = 1'b1;
        axiWrite(CTRL_ADDR, 32'h0, resp);
        expectEq("bresp", RESP_OKAY, resp);
        axiRead(STATUS_ADDR, data, resp);
        expectEq("status", 32'h2, data);
        checkBins(packCplx(IMPULSE_BIN, 0), packCplx(IMPULSE_BIN, 0));
        stallEn = 1'b0;
        repeat (2) @(negedge clock);

        if (dut.uSva.errCount == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Bound protocol checks reported %0d failures.", dut.uSva.errCount);
            $display("Simulation FAILED");
            $fatal(1, "Run stopped after protocol check failures.");
        end
    end

endmodule

`default_nettype wire

//--- test/fftTop_sva.sv
`timescale 1ns/1ns
`default_nettype none

module fftTopSva import fftPkg::*; (
    input logic                  clock_i,
    input logic                  arstN_i,
    input logic                  bvalid_i,
    input logic                  bready_i,
    input logic [1:0]            bresp_i,
    input logic                  rvalid_i,
    input logic                  rready_i,
    input logic [AXI_DATA_W-1:0] rdata_i,
    input logic [1:0]            rresp_i,
    input logic                  busy_i,
    input logic                  done_i
);

    int errCount = 0;

    // A response that is not taken must not move.
    bHeld: assert property (@(posedge clock_i) disable iff (!arstN_i)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
        $error("Write response changed before bready.");
        errCount++;
    end

    rHeld: assert property (@(posedge clock_i) disable iff (!arstN_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
        $error("Read response changed before rready.");
        errCount++;
    end

    resetIdle: assert property (@(posedge clock_i)
        !arstN_i |-> !busy_i && !done_i && !bvalid_i && !rvalid_i)
    else begin
        $error("Core is not idle during reset.");
        errCount++;
    end

    busyDoneExcl: assert property (@(posedge clock_i) disable iff (!arstN_i)
        !(busy_i && done_i))
    else begin
        $error("Busy and done are high together.");
        errCount++;
    end

endmodule

bind fftTop fftTopSva uSva (
    .clock_i  (clock_i),
    .arstN_i  (arstN_i),
    .bvalid_i (bvalid_o),
    .bready_i (bready_i),
    .bresp_i  (bresp_o),
    .rvalid_i (rvalid_o),
    .rready_i (rready_i),
    .rdata_i  (rdata_o),
    .rresp_i  (rresp_o),
    .busy_i   (busy),
    .done_i   (done)
);

`default_nettype wire
